//--- hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // integer datapath width
    localparam int xlen = 64;

    // major opcodes of the supported classes
    localparam logic [6:0] opc_lui      = 7'b0110111;
    localparam logic [6:0] opc_auipc    = 7'b0010111;
    localparam logic [6:0] opc_jal      = 7'b1101111;
    localparam logic [6:0] opc_jalr     = 7'b1100111;
    localparam logic [6:0] opc_branch   = 7'b1100011;
    localparam logic [6:0] opc_op_imm   = 7'b0010011;
    localparam logic [6:0] opc_op       = 7'b0110011;
    localparam logic [6:0] opc_op_imm32 = 7'b0011011;
    localparam logic [6:0] opc_op32     = 7'b0111011;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // arithmetic funct3, shared by reg and imm forms
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // sub and sra select
    localparam logic [6:0] funct7_alt = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    // one instruction word, two field layouts
    typedef union packed {
        rv_r_fmt_t r;
        rv_i_fmt_t i;
    } rv_inst_u;

endpackage

`default_nettype wire

//--- hw/ex_pkg.sv
`default_nettype none

package ex_pkg;

    // datapath word and register index
    typedef logic [rv_isa_pkg::xlen-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // alu function, word forms share these
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // first operand source
    typedef enum logic [1:0] {
        opa_rs1,
        opa_pc,
        opa_zero
    } opa_sel_e;

    // second operand source
    typedef enum logic [1:0] {
        opb_rs2,
        opb_imm,
        opb_four
    } opb_sel_e;

endpackage

`default_nettype wire

//--- hw/ex_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ex_ctrl_if;
    ex_pkg::alu_op_e  alu_op;
    ex_pkg::opa_sel_e opa_sel;
    ex_pkg::opb_sel_e opb_sel;
    // 32-bit op with sign-extended result
    logic             is_word;
    // control transfer kind, at most one set
    logic             is_branch;
    logic             is_jal;
    logic             is_jalr;
    logic [2:0]       branch_f3;
    ex_pkg::word_t    imm;
    logic             wen;

    modport dec (output alu_op, opa_sel, opb_sel, is_word, is_branch, is_jal, is_jalr,
                 branch_f3, imm, wen);
    modport alu (input alu_op, opa_sel, opb_sel, is_word, imm);
    modport br (input is_branch, is_jal, is_jalr, branch_f3, imm);
endinterface

`default_nettype wire

//--- hw/ex_issue_reg.sv
`timescale 1ns/1ns
`default_nettype none

module ex_issue_reg (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 ready,
    input  logic                 in_valid,
    input  ex_pkg::word_t        in_pc,
    input  rv_isa_pkg::rv_inst_u in_inst,
    input  ex_pkg::word_t        rs1_data,
    input  ex_pkg::word_t        rs2_data,
    output logic                 valid,
    output ex_pkg::word_t        pc,
    output rv_isa_pkg::rv_inst_u inst,
    output ex_pkg::word_t        rs1_val,
    output ex_pkg::word_t        rs2_val
);

    // occupancy bit
    // flush drops the in-flight instruction
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= 1'b0;
        end else if (ready) begin
            valid <= in_valid;
        end
    end

    // payload follows the same load enable
    // stale contents are harmless while valid is low
    always_ff @(posedge clk) begin
        if (ready) begin
            pc      <= in_pc;
            inst    <= in_inst;
            rs1_val <= rs1_data;
            rs2_val <= rs2_data;
        end
    end

    // back-pressure must never let a new instruction in
    hold_blocks_entry: assert property (
        @(posedge clk) disable iff (rst)
        (!ready && !flush) |=> !$rose(valid)
    ) else $error("issue register accepted an instruction while held");

endmodule

`default_nettype wire

//--- hw/ex_decode.sv
`timescale 1ns/1ns
`default_nettype none

module ex_decode (
    input  rv_isa_pkg::rv_inst_u inst,
    input  logic                 valid,
    output ex_pkg::reg_idx_t     rs1,
    output ex_pkg::reg_idx_t     rs2,
    output ex_pkg::reg_idx_t     rd,
    ex_ctrl_if.dec               ctrl
);

    ex_pkg::word_t imm_i;
    ex_pkg::word_t imm_b;
    ex_pkg::word_t imm_j;
    ex_pkg::word_t imm_u;
    logic          writes;

    // funct3 to alu op, alt picks sub or sra
    function automatic ex_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            rv_isa_pkg::f3_add:  return alt ? ex_pkg::alu_sub : ex_pkg::alu_add;
            rv_isa_pkg::f3_sll:  return ex_pkg::alu_sll;
            rv_isa_pkg::f3_slt:  return ex_pkg::alu_slt;
            rv_isa_pkg::f3_sltu: return ex_pkg::alu_sltu;
            rv_isa_pkg::f3_xor:  return ex_pkg::alu_xor;
            rv_isa_pkg::f3_sr:   return alt ? ex_pkg::alu_sra : ex_pkg::alu_srl;
            rv_isa_pkg::f3_or:   return ex_pkg::alu_or;
            default:             return ex_pkg::alu_and;
        endcase
    endfunction

    // register fields sit in the same place for every format
    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;
    assign rd  = inst.r.rd;

    // immediates, all sign-extended from the top instruction bit
    assign imm_i = {{(rv_isa_pkg::xlen - 12){inst.i.imm[11]}}, inst.i.imm};
    assign imm_b = {{(rv_isa_pkg::xlen - 13){inst.r.funct7[6]}}, inst.r.funct7[6],
                    inst.r.rd[0], inst.r.funct7[5:0], inst.r.rd[4:1], 1'b0};
    // j-type scatters bits over the rs1, funct3 and imm fields
    assign imm_j = {{(rv_isa_pkg::xlen - 21){inst.i.imm[11]}}, inst.i.imm[11],
                    inst.i.rs1, inst.i.funct3, inst.i.imm[0], inst.i.imm[10:1], 1'b0};
    assign imm_u = {{(rv_isa_pkg::xlen - 32){inst.i.imm[11]}}, inst.i.imm,
                    inst.i.rs1, inst.i.funct3, 12'b0};

    always_comb begin
        ctrl.alu_op    = ex_pkg::alu_add;
        ctrl.opa_sel   = ex_pkg::opa_rs1;
        ctrl.opb_sel   = ex_pkg::opb_rs2;
        ctrl.is_word   = 1'b0;
        ctrl.is_branch = 1'b0;
        ctrl.is_jal    = 1'b0;
        ctrl.is_jalr   = 1'b0;
        ctrl.branch_f3 = inst.r.funct3;
        ctrl.imm       = imm_i;
        writes         = 1'b0;
        case (inst.r.opcode)
            rv_isa_pkg::opc_lui: begin
                ctrl.opa_sel = ex_pkg::opa_zero;
                ctrl.opb_sel = ex_pkg::opb_imm;
                ctrl.imm     = imm_u;
                writes       = 1'b1;
            end
            rv_isa_pkg::opc_auipc: begin
                ctrl.opa_sel = ex_pkg::opa_pc;
                ctrl.opb_sel = ex_pkg::opb_imm;
                ctrl.imm     = imm_u;
                writes       = 1'b1;
            end
            // jumps write the link address pc + 4
            rv_isa_pkg::opc_jal: begin
                ctrl.opa_sel = ex_pkg::opa_pc;
                ctrl.opb_sel = ex_pkg::opb_four;
                ctrl.is_jal  = 1'b1;
                ctrl.imm     = imm_j;
                writes       = 1'b1;
            end
            rv_isa_pkg::opc_jalr: begin
                ctrl.opa_sel = ex_pkg::opa_pc;
                ctrl.opb_sel = ex_pkg::opb_four;
                ctrl.is_jalr = 1'b1;
                writes       = 1'b1;
            end
            rv_isa_pkg::opc_branch: begin
                ctrl.is_branch = 1'b1;
                ctrl.imm       = imm_b;
            end
            // shift-right type lives in bit 30, i.e. imm[10]
            rv_isa_pkg::opc_op_imm, rv_isa_pkg::opc_op_imm32: begin
                ctrl.opb_sel = ex_pkg::opb_imm;
                ctrl.alu_op  = arith_op(inst.i.funct3,
                                        inst.i.funct3 == rv_isa_pkg::f3_sr && inst.i.imm[10]);
                ctrl.is_word = inst.i.opcode == rv_isa_pkg::opc_op_imm32;
                writes       = 1'b1;
            end
            rv_isa_pkg::opc_op, rv_isa_pkg::opc_op32: begin
                ctrl.alu_op  = arith_op(inst.r.funct3,
                                        inst.r.funct7 == rv_isa_pkg::funct7_alt);
                ctrl.is_word = inst.r.opcode == rv_isa_pkg::opc_op32;
                writes       = 1'b1;
            end
            default: begin
                // unknown opcode, no side effects
                writes = 1'b0;
            end
        endcase
        // x0 is never written
        ctrl.wen = valid && writes && (inst.r.rd != '0);
    end

    always_comb begin
        assert ($onehot0({ctrl.is_branch, ctrl.is_jal, ctrl.is_jalr}))
        else $error("decode flagged more than one control transfer kind");
    end

endmodule

`default_nettype wire

//--- hw/operand_forward.sv
`timescale 1ns/1ns
`default_nettype none

module operand_forward (
    input  ex_pkg::reg_idx_t rs1,
    input  ex_pkg::reg_idx_t rs2,
    input  ex_pkg::word_t    rs1_val,
    input  ex_pkg::word_t    rs2_val,
    input  logic             mem_wen,
    input  ex_pkg::reg_idx_t mem_rd,
    input  ex_pkg::word_t    mem_data,
    input  logic             wb_wen,
    input  ex_pkg::reg_idx_t wb_rd,
    input  ex_pkg::word_t    wb_data,
    output ex_pkg::word_t    op1,
    output ex_pkg::word_t    op2
);

    // youngest producer wins, mem ahead of wb
    function automatic ex_pkg::word_t bypass(input ex_pkg::reg_idx_t src,
                                             input ex_pkg::word_t rf_val);
        if (src == '0) begin
            return rf_val;
        end else if (mem_wen && mem_rd == src) begin
            return mem_data;
        end else if (wb_wen && wb_rd == src) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        op1 = bypass(rs1, rs1_val);
        op2 = bypass(rs2, rs2_val);
    end

    // the memory stage never claims a write to x0
    always_comb begin
        assert (!(mem_wen && mem_rd == '0))
        else $error("memory stage reports a write to x0");
    end

endmodule

`default_nettype wire

//--- hw/ex_alu.sv
`timescale 1ns/1ns
`default_nettype none

module ex_alu (
    ex_ctrl_if.alu        ctrl,
    input  ex_pkg::word_t pc,
    input  ex_pkg::word_t op1,
    input  ex_pkg::word_t op2,
    output ex_pkg::word_t result
);

    ex_pkg::word_t a;
    ex_pkg::word_t b;
    ex_pkg::word_t a_sh;
    ex_pkg::word_t raw;
    logic [5:0]    shamt;

    // operand muxes
    always_comb begin
        case (ctrl.opa_sel)
            ex_pkg::opa_pc:   a = pc;
            ex_pkg::opa_zero: a = '0;
            default:          a = op1;
        endcase
        case (ctrl.opb_sel)
            ex_pkg::opb_imm:  b = ctrl.imm;
            ex_pkg::opb_four: b = ex_pkg::word_t'(4);
            default:          b = op2;
        endcase
    end

    // word shifts use five bits
    assign shamt = ctrl.is_word ? {1'b0, b[4:0]} : b[5:0];

    // word right shifts see only the 32-bit source
    // sra needs its sign bits above bit 31
    always_comb begin
        a_sh = a;
        if (ctrl.is_word) begin
            if (ctrl.alu_op == ex_pkg::alu_sra) begin
                a_sh = {{(rv_isa_pkg::xlen - 32){a[31]}}, a[31:0]};
            end else begin
                a_sh = {{(rv_isa_pkg::xlen - 32){1'b0}}, a[31:0]};
            end
        end
    end

    always_comb begin
        case (ctrl.alu_op)
            ex_pkg::alu_sub:  raw = a - b;
            ex_pkg::alu_sll:  raw = a_sh << shamt;
            ex_pkg::alu_slt:  raw = ex_pkg::word_t'($signed(a) < $signed(b));
            ex_pkg::alu_sltu: raw = ex_pkg::word_t'(a < b);
            ex_pkg::alu_xor:  raw = a ^ b;
            ex_pkg::alu_srl:  raw = a_sh >> shamt;
            ex_pkg::alu_sra:  raw = $signed(a_sh) >>> shamt;
            ex_pkg::alu_or:   raw = a | b;
            ex_pkg::alu_and:  raw = a & b;
            default:          raw = a + b;
        endcase
    end

    // word forms sign-extend bit 31
    assign result = ctrl.is_word ? {{(rv_isa_pkg::xlen - 32){raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

//--- hw/branch_resolve.sv
`timescale 1ns/1ns
`default_nettype none

module branch_resolve (
    ex_ctrl_if.br         ctrl,
    input  logic          valid,
    input  logic          ready,
    input  ex_pkg::word_t pc,
    input  ex_pkg::word_t op1,
    input  ex_pkg::word_t op2,
    output logic          redirect,
    output ex_pkg::word_t redirect_pc
);

    logic          cond;
    logic          taken;
    ex_pkg::word_t jalr_sum;

    // compare forwarded operands
    always_comb begin
        case (ctrl.branch_f3)
            rv_isa_pkg::f3_beq:  cond = op1 == op2;
            rv_isa_pkg::f3_bne:  cond = op1 != op2;
            rv_isa_pkg::f3_blt:  cond = $signed(op1) < $signed(op2);
            rv_isa_pkg::f3_bge:  cond = $signed(op1) >= $signed(op2);
            rv_isa_pkg::f3_bltu: cond = op1 < op2;
            rv_isa_pkg::f3_bgeu: cond = op1 >= op2;
            default:             cond = 1'b0;
        endcase
    end

    // jumps always taken
    assign taken = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && cond);

    // jalr target has bit 0 cleared
    assign jalr_sum    = op1 + ctrl.imm;
    assign redirect_pc = ctrl.is_jalr ? {jalr_sum[rv_isa_pkg::xlen-1:1], 1'b0}
                                      : pc + ctrl.imm;

    // only fire when the instruction actually leaves the stage
    assign redirect = valid && ready && taken;

endmodule

`default_nettype wire

//--- hw/ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  ex_pkg::word_t    in_pc,
    input  logic [31:0]      in_inst,
    input  ex_pkg::word_t    rs1_data,
    input  ex_pkg::word_t    rs2_data,
    input  logic             mem_wen,
    input  ex_pkg::reg_idx_t mem_rd,
    input  ex_pkg::word_t    mem_data,
    input  logic             wb_wen,
    input  ex_pkg::reg_idx_t wb_rd,
    input  ex_pkg::word_t    wb_data,
    input  logic             flush,
    output logic             out_valid,
    input  logic             out_ready,
    output ex_pkg::reg_idx_t out_rd,
    output logic             out_wen,
    output ex_pkg::word_t    out_result,
    output logic             redirect,
    output ex_pkg::word_t    redirect_pc
);

    logic                 valid;
    ex_pkg::word_t        pc;
    rv_isa_pkg::rv_inst_u inst;
    ex_pkg::word_t        rs1_val;
    ex_pkg::word_t        rs2_val;
    ex_pkg::reg_idx_t     rs1;
    ex_pkg::reg_idx_t     rs2;
    ex_pkg::word_t        op1;
    ex_pkg::word_t        op2;

    ex_ctrl_if ctrl ();

    // no internal stall source, only downstream back-pressure
    assign in_ready  = out_ready;
    assign out_valid = valid;
    assign out_wen   = ctrl.wen;

    ex_issue_reg u_issue (
        .clk(clk), .rst(rst), .flush(flush), .ready(out_ready),
        .in_valid(in_valid), .in_pc(in_pc), .in_inst(in_inst),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .valid(valid), .pc(pc), .inst(inst), .rs1_val(rs1_val), .rs2_val(rs2_val)
    );

    ex_decode u_decode (
        .inst(inst), .valid(valid), .rs1(rs1), .rs2(rs2), .rd(out_rd), .ctrl(ctrl.dec)
    );

    // bypass sampled while the instruction sits in the register
    operand_forward u_fwd (
        .rs1(rs1), .rs2(rs2), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .mem_wen(mem_wen), .mem_rd(mem_rd), .mem_data(mem_data),
        .wb_wen(wb_wen), .wb_rd(wb_rd), .wb_data(wb_data),
        .op1(op1), .op2(op2)
    );

    ex_alu u_alu (
        .ctrl(ctrl.alu), .pc(pc), .op1(op1), .op2(op2), .result(out_result)
    );

    branch_resolve u_br (
        .ctrl(ctrl.br), .valid(valid), .ready(out_ready), .pc(pc), .op1(op1), .op2(op2),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

endmodule

`default_nettype wire

//--- tb/ex_model.svh
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// reference model of the execute stage, raw bit slicing of the instruction word

// bypass priority: memory stage, then writeback, then register file
// x0 always reads as the register-file value
function automatic logic [63:0] fwd_model(input logic [4:0] src, input logic [63:0] rf,
                                          input logic m_wen, input logic [4:0] m_rd,
                                          input logic [63:0] m_data,
                                          input logic w_wen, input logic [4:0] w_rd,
                                          input logic [63:0] w_data);
    if (src == 5'd0) begin
        return rf;
    end
    if (m_wen && m_rd == src) begin
        return m_data;
    end
    if (w_wen && w_rd == src) begin
        return w_data;
    end
    return rf;
endfunction

// 64-bit arithmetic, six-bit shift amount
function automatic logic [63:0] alu64_model(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] a, input logic [63:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[5:0];
        3'd2: return {63'd0, $signed(a) < $signed(b)};
        3'd3: return {63'd0, a < b};
        3'd4: return a ^ b;
        3'd5: return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// word forms: low 32 bits only, result sign-extended from bit 31
function automatic logic [63:0] alu32_model(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] a, input logic [63:0] b);
    logic [31:0] r;
    case (f3)
        3'd0: r = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
        3'd1: r = a[31:0] << b[4:0];
        3'd5: r = alt ? 32'($signed(a[31:0]) >>> b[4:0]) : a[31:0] >> b[4:0];
        default: r = 32'd0;
    endcase
    return {{32{r[31]}}, r};
endfunction

function automatic logic branch_model(input logic [2:0] f3, input logic [63:0] a,
                                      input logic [63:0] b);
    case (f3)
        3'b000: return a == b;
        3'b001: return a != b;
        3'b100: return $signed(a) < $signed(b);
        3'b101: return $signed(a) >= $signed(b);
        3'b110: return a < b;
        3'b111: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// full stage prediction for one instruction leaving with out_ready high
function automatic void exec_model(input logic [31:0] ins, input logic [63:0] pc,
                                   input logic [63:0] a, input logic [63:0] b,
                                   output logic [63:0] res, output logic chk,
                                   output logic wen, output logic redir,
                                   output logic [63:0] tgt);
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    logic [63:0] imm_j;
    logic [63:0] imm_b;
    logic [2:0]  f3;
    logic        writes;
    f3     = ins[14:12];
    imm_i  = {{52{ins[31]}}, ins[31:20]};
    imm_u  = {{32{ins[31]}}, ins[31:12], 12'd0};
    imm_j  = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_b  = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    res    = 64'd0;
    writes = 1'b0;
    redir  = 1'b0;
    tgt    = 64'd0;
    case (ins[6:0])
        7'b0110111: begin
            res    = imm_u;
            writes = 1'b1;
        end
        7'b0010111: begin
            res    = pc + imm_u;
            writes = 1'b1;
        end
        7'b1101111: begin
            res    = pc + 64'd4;
            writes = 1'b1;
            redir  = 1'b1;
            tgt    = pc + imm_j;
        end
        7'b1100111: begin
            res    = pc + 64'd4;
            writes = 1'b1;
            redir  = 1'b1;
            tgt    = (a + imm_i) & ~64'd1;
        end
        7'b1100011: begin
            redir = branch_model(f3, a, b);
            tgt   = pc + imm_b;
        end
        7'b0010011: begin
            res    = alu64_model(f3, ins[30] && f3 == 3'd5, a, imm_i);
            writes = 1'b1;
        end
        7'b0110011: begin
            res    = alu64_model(f3, ins[30], a, b);
            writes = 1'b1;
        end
        7'b0011011: begin
            res    = alu32_model(f3, ins[30] && f3 == 3'd5, a, imm_i);
            writes = 1'b1;
        end
        7'b0111011: begin
            res    = alu32_model(f3, ins[30], a, b);
            writes = 1'b1;
        end
        default: begin
            writes = 1'b0;
        end
    endcase
    chk = writes;
    wen = writes && ins[11:7] != 5'd0;
endfunction

`endif

//--- tb/tb_ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ex_stage;

    `include "ex_model.svh"

    localparam int timeout_cycles = 20;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [63:0] in_pc;
    logic [31:0] in_inst;
    logic [63:0] rs1_data;
    logic [63:0] rs2_data;
    logic        mem_wen;
    logic [4:0]  mem_rd;
    logic [63:0] mem_data;
    logic        wb_wen;
    logic [4:0]  wb_rd;
    logic [63:0] wb_data;
    logic        flush;
    logic        out_valid;
    logic        out_ready;
    logic [4:0]  out_rd;
    logic        out_wen;
    logic [63:0] out_result;
    logic        redirect;
    logic [63:0] redirect_pc;

    // lcg state
    logic [31:0] seed = 32'd23;

    // expected values of the instruction in flight
    logic [63:0] exp_result;
    logic [4:0]  exp_rd;
    logic        exp_chk;
    logic        exp_wen;
    logic        exp_redir;
    logic [63:0] exp_tgt;

    ex_stage DUT (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
        .in_pc(in_pc), .in_inst(in_inst), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .mem_wen(mem_wen), .mem_rd(mem_rd), .mem_data(mem_data),
        .wb_wen(wb_wen), .wb_rd(wb_rd), .wb_data(wb_data), .flush(flush),
        .out_valid(out_valid), .out_ready(out_ready), .out_rd(out_rd), .out_wen(out_wen),
        .out_result(out_result), .redirect(redirect), .redirect_pc(redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // small pick from the upper, better mixed bits
    function automatic logic [31:0] pick(input int n);
        return (next_rand() >> 16) % n;
    endfunction

    // mix of wide, small signed and 32-bit edge values
    function automatic logic [63:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        case (pick(4))
            0: return {hi, lo};
            1: return {{56{lo[7]}}, lo[7:0]};
            2: return {32'd0, lo};
            default: return {32'hffffffff, lo};
        endcase
    endfunction

    function automatic logic [31:0] build_inst(input int cls);
        rv_isa_pkg::rv_inst_u u;
        logic [2:0] word_f3 [3];
        logic [2:0] br_f3 [6];
        logic [31:0] r;
        word_f3 = '{3'd0, 3'd1, 3'd5};
        br_f3   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        r       = next_rand();
        u       = r;
        // few registers, so forwarding hits often
        u.r.rd  = 5'(pick(4));
        u.r.rs1 = 5'(pick(4));
        u.r.rs2 = 5'(pick(4));
        case (cls)
            0, 2: begin
                u.r.opcode = (cls == 0) ? rv_isa_pkg::opc_op : rv_isa_pkg::opc_op32;
                u.r.funct3 = (cls == 0) ? 3'(pick(8)) : word_f3[pick(3)];
                u.r.funct7 = 7'd0;
                if ((u.r.funct3 == 3'd0 || u.r.funct3 == 3'd5) && pick(2) == 1) begin
                    u.r.funct7 = rv_isa_pkg::funct7_alt;
                end
            end
            1: begin
                u.i.opcode = rv_isa_pkg::opc_op_imm;
                u.i.funct3 = 3'(pick(8));
                if (u.i.funct3 == 3'd1) begin
                    u.i.imm = {6'd0, r[29:24]};
                end else if (u.i.funct3 == 3'd5) begin
                    u.i.imm = {1'b0, r[30], 4'd0, r[29:24]};
                end
            end
            3: begin
                u.i.opcode = rv_isa_pkg::opc_op_imm32;
                u.i.funct3 = word_f3[pick(3)];
                if (u.i.funct3 != 3'd0) begin
                    u.i.imm = {1'b0, u.i.funct3 == 3'd5 && r[30], 5'd0, r[28:24]};
                end
            end
            4: u.r.opcode = rv_isa_pkg::opc_lui;
            5: u.r.opcode = rv_isa_pkg::opc_auipc;
            6: u.r.opcode = rv_isa_pkg::opc_jal;
            7: begin
                u.i.opcode = rv_isa_pkg::opc_jalr;
                u.i.funct3 = 3'd0;
            end
            8: begin
                u.r.opcode = rv_isa_pkg::opc_branch;
                u.r.funct3 = br_f3[pick(6)];
            end
            default: u.r.opcode = 7'b0001111;
        endcase
        return u;
    endfunction

    task automatic abort(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
        assert (exp === act)
        else abort($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
    endtask

    // new random instruction, operands and bypass state, plus its prediction
    task automatic load_txn();
        logic [31:0] pc_hi;
        logic [31:0] pc_lo;
        logic [63:0] a;
        logic [63:0] b;
        pc_hi    = next_rand();
        pc_lo    = next_rand();
        in_pc    = {pc_hi, pc_lo[31:2], 2'b00};
        in_inst  = build_inst(int'(pick(10)));
        exp_rd   = in_inst[11:7];
        rs1_data = rand_word();
        rs2_data = (pick(4) == 0) ? rs1_data : rand_word();
        mem_wen  = pick(2) == 1;
        mem_rd   = 5'(pick(3) + 1);
        mem_data = rand_word();
        // writeback may name x0, which must never bypass
        wb_wen   = pick(2) == 1;
        wb_rd    = 5'(pick(4));
        wb_data  = rand_word();
        a = fwd_model(in_inst[19:15], rs1_data, mem_wen, mem_rd, mem_data,
                      wb_wen, wb_rd, wb_data);
        b = fwd_model(in_inst[24:20], rs2_data, mem_wen, mem_rd, mem_data,
                      wb_wen, wb_rd, wb_data);
        exec_model(in_inst, in_pc, a, b, exp_result, exp_chk, exp_wen, exp_redir, exp_tgt);
    endtask

    task automatic check_outputs(input string name, input logic ready_now);
        check_val({name, " out_valid"}, 64'd1, 64'(out_valid));
        check_val({name, " in_ready"}, 64'(ready_now), 64'(in_ready));
        check_val({name, " out_rd"}, 64'(exp_rd), 64'(out_rd));
        check_val({name, " out_wen"}, 64'(exp_wen), 64'(out_wen));
        if (exp_chk) begin
            check_val({name, " out_result"}, exp_result, out_result);
        end
        // redirect only fires while the instruction can leave
        check_val({name, " redirect"}, 64'(exp_redir && ready_now), 64'(redirect));
        if (exp_redir && ready_now) begin
            check_val({name, " redirect_pc"}, exp_tgt, redirect_pc);
        end
    endtask

    // present one instruction and wait until it sits in the stage register
    task automatic issue(input string name);
        int cnt;
        @(posedge clk);
        #1;
        load_txn();
        in_valid  = 1'b1;
        out_ready = 1'b1;
        cnt = 0;
        while (!in_ready) begin
            @(posedge clk);
            #1;
            cnt++;
            if (cnt > timeout_cycles) begin
                abort({name, ": timed out waiting for in_ready"});
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        cnt = 0;
        while (!out_valid) begin
            @(posedge clk);
            #1;
            cnt++;
            if (cnt > timeout_cycles) begin
                abort({name, ": timed out waiting for out_valid"});
            end
        end
    endtask

    // hold the stage for a few cycles, offering a different instruction and operands
    task automatic stall_test(input string name);
        int n;
        issue(name);
        out_ready = 1'b0;
        in_valid  = 1'b1;
        in_pc     = in_pc + 64'd4;
        in_inst   = build_inst(int'(pick(10)));
        rs1_data  = rand_word();
        rs2_data  = rand_word();
        n = int'(pick(4)) + 1;
        #2;
        for (int k = 0; k <= n; k++) begin
            check_outputs({name, " held"}, 1'b0);
            @(posedge clk);
            #3;
        end
        #6;
        out_ready = 1'b1;
        in_valid  = 1'b0;
        #2;
        check_outputs({name, " released"}, 1'b1);
    endtask

    // drop the in-flight instruction with flush or reset
    task automatic drop_test(input string name, input logic use_rst);
        issue(name);
        // upstream keeps offering while the stage is dropped
        in_valid = 1'b1;
        if (use_rst) begin
            rst = 1'b1;
        end else begin
            flush = 1'b1;
        end
        @(posedge clk);
        #1;
        rst      = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        #2;
        check_val({name, " out_valid"}, 64'd0, 64'(out_valid));
        check_val({name, " out_wen"}, 64'd0, 64'(out_wen));
        check_val({name, " redirect"}, 64'd0, 64'(redirect));
    endtask

    initial begin
        rst       = 1'b1;
        // upstream already offering during reset
        in_valid  = 1'b1;
        in_pc     = '0;
        in_inst   = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        mem_wen   = 1'b0;
        mem_rd    = '0;
        mem_data  = '0;
        wb_wen    = 1'b0;
        wb_rd     = '0;
        wb_data   = '0;
        flush     = 1'b0;
        out_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst      = 1'b0;
        in_valid = 1'b0;
        #2;
        check_val("reset out_valid", 64'd0, 64'(out_valid));
        check_val("reset out_wen", 64'd0, 64'(out_wen));
        check_val("reset redirect", 64'd0, 64'(redirect));

        // alu, word forms, forwarding, branches and jumps
        for (int t = 0; t < 400; t++) begin
            issue($sformatf("random %0d", t));
            #2;
            check_outputs($sformatf("random %0d", t), 1'b1);
        end
        for (int t = 0; t < 30; t++) begin
            stall_test($sformatf("stall %0d", t));
        end
        for (int t = 0; t < 10; t++) begin
            drop_test($sformatf("flush %0d", t), 1'b0);
            drop_test($sformatf("reset %0d", t), 1'b1);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hw/rv_isa_pkg.sv
hw/ex_pkg.sv
hw/ex_ctrl_if.sv
hw/ex_issue_reg.sv
hw/ex_decode.sv
hw/operand_forward.sv
hw/ex_alu.sv
hw/branch_resolve.sv
hw/ex_stage.sv
+incdir+tb
tb/tb_ex_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP VFLAGS OBJ_DIR"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f src.f
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
